//--- logic/lpc_consts.svh
`ifndef LPC_CONSTS_SVH
`define LPC_CONSTS_SVH

// Recursion order N, works for 2 to 15
`define LPC_ORDER 10
// Index width, enough for order 15
`define LPC_IDX_W 4
// Coefficient and sample width
`define LPC_DATA_W 16
// Accumulator and prediction error width
`define LPC_ACC_W 40

// Q15 to Q12 distance
`define LPC_A_SHIFT 3
// r in Q15 raised to the Q27 product scale
`define LPC_R_SHIFT 12
// Renormalise a Q15 product
`define LPC_Q15_SHIFT 15

// Restoring divider, one quotient bit per cycle
`define LPC_DIV_STEPS 32

// Symmetric 16-bit limits
`define LPC_SAT_MAX 32767
`define LPC_SAT_MIN (-32767)

`endif

//--- logic/lpc_ctrl_pkg.sv
`default_nettype none

package lpc_ctrl_pkg;

	// Sequencer states
	// DOT to ERROR repeats once per order
	typedef enum logic [2:0]
	{
		IDLE,
		INIT,
		DOT,
		DIVIDE,
		UPDATE,
		COPY,
		ERROR,
		DONE
	} lpc_state_e;

	// Arithmetic unit opcodes
	typedef enum logic [2:0]
	{
		OP_NONE,
		// Zero acc, load err with r[0]
		OP_CLEAR,
		OP_MAC,
		OP_DIV,
		// a[j] update, result combinational
		OP_UPD,
		OP_ERR
	} lpc_op_e;

endpackage

`default_nettype wire

//--- logic/lpc_bus_pkg.sv
`default_nettype none
`include "lpc_consts.svh"

package lpc_bus_pkg;

	// Host write of one r value, 21 bits
	typedef struct packed
	{
		logic valid;
		logic [`LPC_IDX_W-1:0] index;
		logic signed [`LPC_DATA_W-1:0] data;
	} lpc_load_t;

	// Host read request
	// kind 0 selects a, kind 1 selects k
	typedef struct packed
	{
		logic kind;
		logic [`LPC_IDX_W-1:0] index;
	} lpc_read_t;

	// Operands picked by i and j
	typedef struct packed
	{
		logic signed [`LPC_DATA_W-1:0] r_i;
		logic signed [`LPC_DATA_W-1:0] r_ij;
		logic signed [`LPC_DATA_W-1:0] a_prev_j;
		logic signed [`LPC_DATA_W-1:0] a_prev_ij;
		logic signed [`LPC_DATA_W-1:0] r0;
	} lpc_operand_t;

endpackage

`default_nettype wire

//--- logic/lpc_index_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpc_consts.svh"

module lpc_index_counter
(
	input logic clock,
	input logic arst_n,
	input logic clear,
	input logic step_j,
	input logic step_i,
	output logic [`LPC_IDX_W-1:0] i,
	output logic [`LPC_IDX_W-1:0] j,
	output logic i_last,
	output logic j_last
);

	localparam logic [`LPC_IDX_W-1:0] IDX_ONE = 1;
	localparam logic [`LPC_IDX_W-1:0] LAST_I = `LPC_ORDER;

	// Order i outer, inner index j
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			i <= IDX_ONE;
			j <= IDX_ONE;
		end
		else if (clear)
		begin
			i <= IDX_ONE;
			j <= IDX_ONE;
		end
		else if (step_i)
		begin
			// New order, inner loop restarts
			i <= i + IDX_ONE;
			j <= IDX_ONE;
		end
		else if (step_j)
		begin
			// Wrap so UPDATE starts at 1 after DOT
			j <= j_last ? IDX_ONE : j + IDX_ONE;
		end
	end

	assign i_last = (i == LAST_I);

	// Set once j reaches i-1
	// also set at i = 1, where the inner range is empty
	assign j_last = (({1'b0, j} + 1'b1) >= {1'b0, i});

endmodule

`default_nettype wire

//--- logic/lpc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lpc_sequencer
(
	input logic clock,
	input logic arst_n,
	input logic start,
	input logic i_last,
	input logic j_last,
	input logic div_done,
	output lpc_ctrl_pkg::lpc_op_e op,
	output logic clear,
	output logic step_j,
	output logic step_i,
	output logic we_a,
	output logic we_k,
	output logic copy_a,
	output logic busy,
	output logic done
);

	lpc_ctrl_pkg::lpc_state_e state;
	lpc_ctrl_pkg::lpc_state_e state_next;
	// First order has no a[j] update
	logic order_one;

	//////////////////////////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			state <= lpc_ctrl_pkg::IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			order_one <= 1'b0;
		else if (state == lpc_ctrl_pkg::INIT)
			order_one <= 1'b1;
		else if (state == lpc_ctrl_pkg::ERROR)
			order_one <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			lpc_ctrl_pkg::IDLE:
				if (start)
					state_next = lpc_ctrl_pkg::INIT;
			// i = 1 here, j_last already up so DOT is skipped
			lpc_ctrl_pkg::INIT:
				state_next = j_last ? lpc_ctrl_pkg::DIVIDE : lpc_ctrl_pkg::DOT;
			lpc_ctrl_pkg::DOT:
				if (j_last)
					state_next = lpc_ctrl_pkg::DIVIDE;
			lpc_ctrl_pkg::DIVIDE:
				if (div_done)
					state_next = order_one ? lpc_ctrl_pkg::COPY : lpc_ctrl_pkg::UPDATE;
			lpc_ctrl_pkg::UPDATE:
				if (j_last)
					state_next = lpc_ctrl_pkg::COPY;
			lpc_ctrl_pkg::COPY:
				state_next = lpc_ctrl_pkg::ERROR;
			// Next order always has at least one MAC
			lpc_ctrl_pkg::ERROR:
				state_next = i_last ? lpc_ctrl_pkg::DONE : lpc_ctrl_pkg::DOT;
			default:
				state_next = lpc_ctrl_pkg::IDLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Decoded controls
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op = lpc_ctrl_pkg::OP_NONE;
		case (state)
			lpc_ctrl_pkg::INIT: op = lpc_ctrl_pkg::OP_CLEAR;
			lpc_ctrl_pkg::DOT: op = lpc_ctrl_pkg::OP_MAC;
			lpc_ctrl_pkg::DIVIDE: op = lpc_ctrl_pkg::OP_DIV;
			lpc_ctrl_pkg::UPDATE: op = lpc_ctrl_pkg::OP_UPD;
			lpc_ctrl_pkg::ERROR: op = lpc_ctrl_pkg::OP_ERR;
			default: op = lpc_ctrl_pkg::OP_NONE;
		endcase
	end

	// Counter and banks cleared on the accepted start
	assign clear = (state == lpc_ctrl_pkg::IDLE) && start;
	assign step_j = (state == lpc_ctrl_pkg::DOT) || (state == lpc_ctrl_pkg::UPDATE);
	assign step_i = (state == lpc_ctrl_pkg::ERROR) && !i_last;

	// k[i] and a[i] land when the quotient is ready
	assign we_k = (state == lpc_ctrl_pkg::DIVIDE) && div_done;
	assign we_a = (state == lpc_ctrl_pkg::UPDATE);
	assign copy_a = (state == lpc_ctrl_pkg::COPY);

	assign busy = (state != lpc_ctrl_pkg::IDLE);
	assign done = (state == lpc_ctrl_pkg::DONE);

endmodule

`default_nettype wire

//--- logic/lpc_scratch_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpc_consts.svh"

module lpc_scratch_mem
(
	input logic clock,
	input logic arst_n,
	input lpc_bus_pkg::lpc_load_t load,
	input logic busy,
	input logic [`LPC_IDX_W-1:0] i,
	input logic [`LPC_IDX_W-1:0] j,
	input logic we_a,
	input logic we_k,
	input logic copy_a,
	input logic clear,
	input logic signed [`LPC_DATA_W-1:0] k_out,
	input logic signed [`LPC_DATA_W-1:0] a_out,
	output lpc_bus_pkg::lpc_operand_t operands,
	input lpc_bus_pkg::lpc_read_t rd,
	output logic [`LPC_DATA_W-1:0] rd_data
);

	localparam int N = `LPC_ORDER;

	logic signed [`LPC_DATA_W-1:0] r_bank [0:N];
	logic signed [`LPC_DATA_W-1:0] a_bank [1:N];
	logic signed [`LPC_DATA_W-1:0] a_prev [1:N];
	logic signed [`LPC_DATA_W-1:0] k_bank [1:N];
	logic [`LPC_IDX_W-1:0] idx_ij;
	logic rd_hit;

	// Operand select
	assign idx_ij = i - j;

	always_comb
	begin
		operands.r_i = r_bank[i];
		operands.r_ij = r_bank[idx_ij];
		operands.a_prev_j = a_prev[j];
		// i - j is 0 only at order 1
		operands.a_prev_ij = (idx_ij == '0) ? '0 : a_prev[idx_ij];
		operands.r0 = r_bank[0];
	end

	//////////////////////////////////////////////////////////////////////
	// Bank writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int n = 0; n <= N; n++)
				r_bank[n] <= '0;
			for (int n = 1; n <= N; n++)
			begin
				a_bank[n] <= '0;
				a_prev[n] <= '0;
				k_bank[n] <= '0;
			end
		end
		else
		begin
			// Host load only while idle
			if (load.valid && !busy && (load.index <= N))
				r_bank[load.index] <= load.data;
			if (clear)
			begin
				for (int n = 1; n <= N; n++)
				begin
					a_bank[n] <= '0;
					a_prev[n] <= '0;
					k_bank[n] <= '0;
				end
			end
			else if (copy_a)
			begin
				for (int n = 1; n <= N; n++)
					a_prev[n] <= a_bank[n];
			end
			else
			begin
				// New reflection coeff, a[i] is k[i] in Q12
				if (we_k)
				begin
					k_bank[i] <= k_out;
					a_bank[i] <= k_out >>> `LPC_A_SHIFT;
				end
				if (we_a)
					a_bank[j] <= a_out;
			end
		end
	end

	// Host read, one cycle latency
	assign rd_hit = (rd.index != '0) && (rd.index <= N);

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			rd_data <= '0;
		else if (!rd_hit)
			rd_data <= '0;
		else if (rd.kind)
			rd_data <= k_bank[rd.index];
		else
			rd_data <= a_bank[rd.index];
	end

endmodule

`default_nettype wire

//--- logic/lpc_arith_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpc_consts.svh"

module lpc_arith_unit
(
	input logic clock,
	input logic arst_n,
	input lpc_ctrl_pkg::lpc_op_e op,
	input lpc_bus_pkg::lpc_operand_t operands,
	output logic div_done,
	output logic signed [`LPC_DATA_W-1:0] k_out,
	output logic signed [`LPC_DATA_W-1:0] a_out
);

	localparam int ACC_W = `LPC_ACC_W;
	localparam int DATA_W = `LPC_DATA_W;
	localparam int DVD_W = `LPC_ACC_W + `LPC_A_SHIFT;
	localparam int Q_W = `LPC_DIV_STEPS;
	localparam int CNT_W = $clog2(`LPC_DIV_STEPS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LPC_DIV_STEPS - 1);
	localparam logic signed [DATA_W-1:0] SAT_HI = DATA_W'(`LPC_SAT_MAX);
	localparam logic signed [DATA_W-1:0] SAT_LO = DATA_W'(`LPC_SAT_MIN);
	localparam logic [DATA_W:0] ONE_Q15 = (DATA_W+1)'(1 << `LPC_Q15_SHIFT);

	// Clip to 16 bits
	function automatic logic signed [DATA_W-1:0] sat_data(input logic signed [ACC_W-1:0] v);
		logic signed [DATA_W-1:0] res;
		if (v > `LPC_SAT_MAX)
			res = SAT_HI;
		else if (v < `LPC_SAT_MIN)
			res = SAT_LO;
		else
			res = v[DATA_W-1:0];
		return res;
	endfunction

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] err;
	logic signed [DATA_W-1:0] k_reg;
	logic signed [2*DATA_W-1:0] mac_prod;
	logic signed [ACC_W-1:0] r_ext;
	logic signed [ACC_W-1:0] acc_sum;
	logic [ACC_W-1:0] acc_mag;
	logic [DVD_W-1:0] dvd_mag;
	logic div_start;
	logic div_run;
	logic div_neg;
	logic div_ovf;
	logic [CNT_W-1:0] div_cnt;
	logic [ACC_W-1:0] rem;
	logic [ACC_W-1:0] rem_shift;
	logic [ACC_W:0] rem_diff;
	logic [Q_W-1:0] quo;
	logic [Q_W-1:0] quo_next;
	logic q_bit;
	logic [DATA_W-1:0] k_mag;
	logic signed [2*DATA_W-1:0] upd_prod;
	logic signed [ACC_W-1:0] upd_sum;
	logic signed [2*DATA_W-1:0] kk_prod;
	logic [DATA_W:0] err_factor;
	logic signed [ACC_W+DATA_W+1:0] err_prod;
	logic signed [ACC_W-1:0] err_scaled;
	logic signed [ACC_W-1:0] err_next;

	//////////////////////////////////////////////////////////////////////
	// Combinational datapath
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Q12 times Q15, Q27 sum
		mac_prod = operands.a_prev_j * operands.r_ij;
		r_ext = operands.r_i;
		acc_sum = acc + (r_ext <<< `LPC_R_SHIFT);
		// Divide magnitudes, Q30 over Q15
		acc_mag = acc_sum[ACC_W-1] ? -acc_sum : acc_sum;
		dvd_mag = {acc_mag, `LPC_A_SHIFT'(0)};

		// One restoring step
		rem_shift = {rem[ACC_W-2:0], quo[Q_W-1]};
		rem_diff = {1'b0, rem_shift} - {1'b0, err};
		q_bit = !rem_diff[ACC_W];
		quo_next = {quo[Q_W-2:0], q_bit};
		k_mag = (div_ovf || (quo_next > `LPC_SAT_MAX)) ? SAT_HI : quo_next[DATA_W-1:0];

		// a[j] + k * a[i-j], back to Q12
		upd_prod = k_reg * operands.a_prev_ij;
		upd_sum = operands.a_prev_j + (upd_prod >>> `LPC_Q15_SHIFT);
		a_out = sat_data(upd_sum);

		// err * (1 - k^2), floor of 1
		kk_prod = k_reg * k_reg;
		err_factor = ONE_Q15 - kk_prod[2*DATA_W-1:`LPC_Q15_SHIFT];
		err_prod = err * $signed({1'b0, err_factor});
		err_scaled = err_prod[ACC_W+`LPC_Q15_SHIFT-1:`LPC_Q15_SHIFT];
		err_next = (err_scaled < 1) ? ACC_W'(1) : err_scaled;
	end

	assign div_start = (op == lpc_ctrl_pkg::OP_DIV) && !div_run && !div_done;
	assign k_out = k_reg;

	//////////////////////////////////////////////////////////////////////
	// Datapath registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		case (op)
			lpc_ctrl_pkg::OP_CLEAR:
			begin
				acc <= '0;
				err <= operands.r0;
			end
			lpc_ctrl_pkg::OP_MAC:
				acc <= acc + mac_prod;
			lpc_ctrl_pkg::OP_ERR:
			begin
				err <= err_next;
				acc <= '0;
			end
			default:
				acc <= acc;
		endcase
		if (div_start)
		begin
			// Top bits seed the remainder, overflow if already >= err
			rem <= ACC_W'(dvd_mag[DVD_W-1:Q_W]);
			quo <= dvd_mag[Q_W-1:0];
			div_ovf <= (ACC_W'(dvd_mag[DVD_W-1:Q_W]) >= err);
			// k takes the opposite sign of acc
			div_neg <= !acc_sum[ACC_W-1];
		end
		else if (div_run)
		begin
			rem <= q_bit ? rem_diff[ACC_W-1:0] : rem_shift;
			quo <= quo_next;
		end
		if (div_run && (div_cnt == CNT_LAST))
			k_reg <= div_neg ? -k_mag : k_mag;
	end

	// Divider control
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_run <= 1'b0;
			div_cnt <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= div_run && (div_cnt == CNT_LAST);
			if (div_start)
			begin
				div_run <= 1'b1;
				div_cnt <= '0;
			end
			else if (div_run)
			begin
				div_cnt <= div_cnt + 1'b1;
				if (div_cnt == CNT_LAST)
					div_run <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/lpc_solver.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpc_consts.svh"

module lpc_solver
(
	input logic clock,
	input logic arst_n,
	input lpc_bus_pkg::lpc_load_t load,
	input logic start,
	input lpc_bus_pkg::lpc_read_t rd,
	output logic [`LPC_DATA_W-1:0] rd_data,
	output logic busy,
	output logic done
);

	// Sequencer controls
	lpc_ctrl_pkg::lpc_op_e op;
	logic clear;
	logic step_j;
	logic step_i;
	logic we_a;
	logic we_k;
	logic copy_a;
	// Indices
	logic [`LPC_IDX_W-1:0] i;
	logic [`LPC_IDX_W-1:0] j;
	logic i_last;
	logic j_last;
	// Datapath
	lpc_bus_pkg::lpc_operand_t operands;
	logic div_done;
	logic signed [`LPC_DATA_W-1:0] k_out;
	logic signed [`LPC_DATA_W-1:0] a_out;

	lpc_index_counter u_index_counter
	(
		.clock(clock),
		.arst_n(arst_n),
		.clear(clear),
		.step_j(step_j),
		.step_i(step_i),
		.i(i),
		.j(j),
		.i_last(i_last),
		.j_last(j_last)
	);

	lpc_sequencer u_sequencer
	(
		.clock(clock),
		.arst_n(arst_n),
		.start(start),
		.i_last(i_last),
		.j_last(j_last),
		.div_done(div_done),
		.op(op),
		.clear(clear),
		.step_j(step_j),
		.step_i(step_i),
		.we_a(we_a),
		.we_k(we_k),
		.copy_a(copy_a),
		.busy(busy),
		.done(done)
	);

	lpc_scratch_mem u_scratch_mem
	(
		.clock(clock),
		.arst_n(arst_n),
		.load(load),
		.busy(busy),
		.i(i),
		.j(j),
		.we_a(we_a),
		.we_k(we_k),
		.copy_a(copy_a),
		.clear(clear),
		.k_out(k_out),
		.a_out(a_out),
		.operands(operands),
		.rd(rd),
		.rd_data(rd_data)
	);

	lpc_arith_unit u_arith_unit
	(
		.clock(clock),
		.arst_n(arst_n),
		.op(op),
		.operands(operands),
		.div_done(div_done),
		.k_out(k_out),
		.a_out(a_out)
	);

endmodule

`default_nettype wire

//--- testbench/lpc_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lpc_clock_gen
(
	output logic clock,
	output logic arst_n
);

	// Reset held for four rising edges
	initial
	begin
		clock = 1'b0;
		arst_n = 1'b0;
		repeat (4) @(posedge clock);
		#1 arst_n = 1'b1;
	end

	// 10 ns period
	always #5 clock = ~clock;

endmodule

`default_nettype wire

//--- testbench/lpc_solver_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpc_consts.svh"

module lpc_solver_properties
(
	input logic clock,
	input logic arst_n,
	input logic busy,
	input logic done,
	input logic [`LPC_IDX_W-1:0] i,
	input logic [`LPC_IDX_W-1:0] j
);

	//////////////////////////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////////////////////////

	// Done is a single-cycle strobe
	done_strobe: assert property (@(posedge clock) disable iff (!arst_n) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Solver back in idle right after done
	idle_after_done: assert property (@(posedge clock) disable iff (!arst_n) done |=> !busy)
		else $error("busy still high in the cycle after done");

	//////////////////////////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////////////////////////

	// Inner index stays inside the current order
	inner_in_range: assert property (@(posedge clock) disable iff (!arst_n) j <= i)
		else $error("inner index j is above order i");

	order_in_range: assert property (@(posedge clock) disable iff (!arst_n)
		(i >= 1) && (i <= `LPC_ORDER))
		else $error("order index i left the range 1 to N");

endmodule

`default_nettype wire

//--- testbench/lpc_solver_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpc_consts.svh"

module lpc_solver_tb;

	localparam int N = `LPC_ORDER;
	localparam int FRAMES = 40;
	localparam int NOISY_FRAMES = 4;
	// Cycle budget of one frame with its loads and reads
	localparam int FRAME_CYCLES = N * 70 + 60;
	localparam int TIMEOUT_CYCLES = FRAMES * FRAME_CYCLES;

	logic clock;
	logic arst_n;
	lpc_bus_pkg::lpc_load_t load;
	logic start;
	lpc_bus_pkg::lpc_read_t rd;
	logic [`LPC_DATA_W-1:0] rd_data;
	logic busy;
	logic done;

	integer seed;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	// Current frame and its model results
	int r_frame [0:N];
	int exp_a [1:N];
	int exp_k [1:N];

	lpc_clock_gen u_clock_gen
	(
		.clock(clock),
		.arst_n(arst_n)
	);

	lpc_solver uut
	(
		.clock(clock),
		.arst_n(arst_n),
		.load(load),
		.start(start),
		.rd(rd),
		.rd_data(rd_data),
		.busy(busy),
		.done(done)
	);

	bind lpc_solver lpc_solver_properties u_properties
	(
		.clock(clock),
		.arst_n(arst_n),
		.busy(busy),
		.done(done),
		.i(i),
		.j(j)
	);

	// Run limit
	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the solver never finished the tests", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		if (got != expected)
		begin
			errors++;
			$display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int span;
		span = hi - lo + 1;
		return lo + int'($unsigned($random(seed)) % span);
	endfunction

	function automatic longint saturate(input longint v);
		if (v > `LPC_SAT_MAX)
			return `LPC_SAT_MAX;
		else if (v < `LPC_SAT_MIN)
			return `LPC_SAT_MIN;
		return v;
	endfunction

	// Kind 1 forces r[1] to r0 and kind 2 to -r0
	task automatic make_frame(input int kind);
		int n;
		r_frame[0] = rand_range(1024, `LPC_SAT_MAX);
		for (n = 1; n <= N; n++)
			r_frame[n] = rand_range(-r_frame[0], r_frame[0]);
		if (kind == 1)
			r_frame[1] = r_frame[0];
		else if (kind == 2)
			r_frame[1] = -r_frame[0];
	endtask

	// Integer Levinson-Durbin on Q15 r and k and Q12 a
	task automatic solve_model();
		longint a_prev [1:N];
		longint a_cur [1:N];
		longint acc;
		longint kv;
		longint err;
		int i;
		int j;
		for (i = 1; i <= N; i++)
		begin
			a_prev[i] = 0;
			a_cur[i] = 0;
		end
		err = r_frame[0];
		for (i = 1; i <= N; i++)
		begin
			// Q27 sum
			acc = longint'(r_frame[i]) * 4096;
			for (j = 1; j < i; j++)
				acc += a_prev[j] * r_frame[i - j];
			// Truncating divide then clip
			kv = saturate(-(acc * 8) / err);
			exp_k[i] = int'(kv);
			a_cur[i] = kv >>> 3;
			for (j = 1; j < i; j++)
				a_cur[j] = saturate(a_prev[j] + ((kv * a_prev[i - j]) >>> 15));
			a_prev = a_cur;
			err = (err * (32768 - ((kv * kv) >>> 15))) >>> 15;
			if (err < 1)
				err = 1;
		end
		for (i = 1; i <= N; i++)
			exp_a[i] = int'(a_cur[i]);
	endtask

	task automatic load_frame();
		int n;
		for (n = 0; n <= N; n++)
		begin
			load.valid = 1'b1;
			load.index = n[`LPC_IDX_W-1:0];
			load.data = `LPC_DATA_W'(r_frame[n]);
			@(posedge clock);
			#1;
		end
		load = '0;
	endtask

	// Noisy run pokes load and start every busy cycle
	task automatic start_and_wait(input bit noisy, output int done_count);
		bit finished;
		done_count = 0;
		finished = 1'b0;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
		while (!finished)
		begin
			if (done)
			begin
				done_count++;
				finished = 1'b1;
			end
			else if (!busy)
			begin
				errors++;
				$display("Busy dropped at %0t before done was seen", $time);
				finished = 1'b1;
			end
			else
			begin
				if (noisy)
				begin
					load.valid = 1'b1;
					load.index = `LPC_IDX_W'(rand_range(0, N));
					load.data = `LPC_DATA_W'(rand_range(-32767, 32767));
					start = (rand_range(0, 1) == 1);
				end
				@(posedge clock);
				#1;
				load = '0;
				start = 1'b0;
			end
		end
		// No second done afterwards
		repeat (4)
		begin
			@(posedge clock);
			#1;
			if (done)
				done_count++;
		end
		check_value("busy after done", busy, 0);
	endtask

	// rd sampled on the next edge and data valid right after it
	task automatic read_value(input logic kind, input int index, output int value);
		rd.kind = kind;
		rd.index = index[`LPC_IDX_W-1:0];
		@(posedge clock);
		#1;
		value = $signed(rd_data);
	endtask

	task automatic check_bank(input logic kind);
		int n;
		int value;
		for (n = 1; n <= N; n++)
		begin
			read_value(kind, n, value);
			if (kind)
				check_value($sformatf("k[%0d]", n), value, exp_k[n]);
			else
				check_value($sformatf("a[%0d]", n), value, exp_a[n]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int kind;
		int n;
		int f;
		int value;
		int dones;
		int mark;
		int err1;
		int err2;
		int err3;
		int err4;
		int err5;
		seed = 32'h68fc7f6c;
		load = '0;
		start = 1'b0;
		rd = '0;
		err2 = 0;
		err3 = 0;
		@(posedge arst_n);
		@(posedge clock);
		#1;

		// Every address reads zero while idle after reset
		mark = errors;
		for (kind = 0; kind < 2; kind++)
			for (n = 0; n < (1 << `LPC_IDX_W); n++)
			begin
				read_value(kind[0], n, value);
				check_value($sformatf("reset read %0d/%0d", kind, n), value, 0);
				check_value("busy", busy, 0);
				check_value("done", done, 0);
			end
		err1 = errors - mark;
		$display("test 1 reset state: %0d errors", err1);

		// Random frames with a and k against the model
		for (f = 0; f < FRAMES; f++)
		begin
			make_frame(0);
			solve_model();
			load_frame();
			start_and_wait(1'b0, dones);
			check_value("done count", dones, 1);
			mark = errors;
			check_bank(1'b0);
			err2 += errors - mark;
			mark = errors;
			check_bank(1'b1);
			err3 += errors - mark;
		end
		$display("test 2 random frames, a: %0d errors", err2);
		$display("test 3 random frames, k: %0d errors", err3);

		// r[1] at +r0 then -r0 drives k[1] to the limits
		mark = errors;
		for (f = 1; f <= 2; f++)
		begin
			make_frame(f);
			solve_model();
			load_frame();
			start_and_wait(1'b0, dones);
			check_value("done count", dones, 1);
			check_bank(1'b0);
			check_bank(1'b1);
			read_value(1'b1, 1, value);
			check_value("k[1] limit", value, (f == 1) ? `LPC_SAT_MIN : `LPC_SAT_MAX);
		end
		err4 = errors - mark;
		$display("test 4 saturation frames: %0d errors", err4);

		// Noise while busy and then a clean rerun on the same r bank
		mark = errors;
		for (f = 0; f < NOISY_FRAMES; f++)
		begin
			make_frame(0);
			solve_model();
			load_frame();
			start_and_wait(1'b1, dones);
			check_value("done count, noisy run", dones, 1);
			check_bank(1'b0);
			check_bank(1'b1);
			start_and_wait(1'b0, dones);
			check_value("done count, rerun", dones, 1);
			check_bank(1'b0);
			check_bank(1'b1);
		end
		err5 = errors - mark;
		$display("test 5 inputs while busy: %0d errors", err5);

		$display("summary: 5 tests, %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- lpc_solver.f
+incdir+logic
logic/lpc_ctrl_pkg.sv
logic/lpc_bus_pkg.sv
logic/lpc_index_counter.sv
logic/lpc_sequencer.sv
logic/lpc_scratch_mem.sv
logic/lpc_arith_unit.sv
logic/lpc_solver.sv
testbench/lpc_clock_gen.sv
testbench/lpc_solver_properties.sv
testbench/lpc_solver_tb.sv

//--- Makefile
# Verilator flow for the Levinson-Durbin solver
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= lpc_solver_tb
FILELIST ?= lpc_solver.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_PATTERN ?= TEST FAILED
PASS_PATTERN ?= TEST OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, then judge the log
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_PATTERN)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
